//--- bench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [15:0] model_regs [16];
logic [15:0] model_mem [MEM_WORDS];
logic [15:0] model_io [$];            // expected io_out sequence.
int          model_cycles;
logic        model_halted;

function automatic logic [15:0] sext8(input logic [7:0] v);
    return {{8{v[7]}}, v};
endfunction

// cycles per instruction, counted from fetch.
function automatic int cycles_for(input cpu_isa_pkg::opcode_e op);
    case (op)
        cpu_isa_pkg::OP_LD:  return 5;
        cpu_isa_pkg::OP_BNZ: return 3;
        cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_OR,
        cpu_isa_pkg::OP_XOR, cpu_isa_pkg::OP_SLT, cpu_isa_pkg::OP_LI, cpu_isa_pkg::OP_ST:
            return 4;
        default:             return 2;   // nop and halt.
    endcase
endfunction

task automatic run_model(input logic [15:0] io_value);
    cpu_isa_pkg::instr_t ins;
    logic [15:0]         pc;
    logic [15:0]         ea;
    logic [15:0]         x;
    logic [15:0]         y;
    int                  steps;
    pc           = '0;
    steps        = 0;
    model_cycles = 0;
    model_halted = 1'b0;
    model_io.delete();
    while (!model_halted && steps < 4 * MEM_WORDS)
    begin
        ins   = cpu_isa_pkg::instr_t'(model_mem[int'(pc) % MEM_WORDS]);
        x     = model_regs[ins.rs1];
        y     = model_regs[ins.rs2];
        ea    = x + 16'(ins.rs2);        // imm4 zero-extended.
        pc    = pc + 16'd1;
        steps = steps + 1;
        model_cycles = model_cycles + cycles_for(ins.op);
        case (ins.op)
            cpu_isa_pkg::OP_ADD: model_regs[ins.rd] = x + y;
            cpu_isa_pkg::OP_SUB: model_regs[ins.rd] = x - y;
            cpu_isa_pkg::OP_AND: model_regs[ins.rd] = x & y;
            cpu_isa_pkg::OP_OR:  model_regs[ins.rd] = x | y;
            cpu_isa_pkg::OP_XOR: model_regs[ins.rd] = x ^ y;
            cpu_isa_pkg::OP_SLT: model_regs[ins.rd] = ($signed(x) < $signed(y)) ? 16'd1 : 16'd0;
            cpu_isa_pkg::OP_LI:  model_regs[ins.rd] = sext8({ins.rs1, ins.rs2});
            cpu_isa_pkg::OP_LD:
            begin
                if (ea == cpu_isa_pkg::IO_ADDR)
                    model_regs[ins.rd] = io_value;
                else
                    model_regs[ins.rd] = model_mem[int'(ea) % MEM_WORDS];
            end
            cpu_isa_pkg::OP_ST:
            begin
                if (ea == cpu_isa_pkg::IO_ADDR)
                    model_io.push_back(model_regs[ins.rd]);
                else
                    model_mem[int'(ea) % MEM_WORDS] = model_regs[ins.rd];
            end
            cpu_isa_pkg::OP_BNZ:
            begin
                if (model_regs[ins.rd] != 16'd0)
                    pc = pc + sext8({ins.rs1, ins.rs2});
            end
            cpu_isa_pkg::OP_HALT: model_halted = 1'b1;
            default: ;
        endcase
    end
endtask

`endif

//--- bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int MEM_WORDS   = 256;
    localparam int NUM_TESTS   = 8;
    localparam int NUM_SLOTS   = 20;            // two words per slot.
    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 5 * 128 + 3 * MEM_WORDS + 50;

    logic                   clock;
    logic                   rst;
    logic                   start;
    logic [15:0]            io_in;
    cpu_ctrl_pkg::mem_req_t host_req;
    logic [15:0]            host_rdata;
    logic [15:0]            io_out;
    logic                   io_out_valid;
    logic                   busy;

    logic [15:0] image [MEM_WORDS];
    int          prog_len;
    logic [15:0] dut_io [$];

    `include "cpu_model.svh"

    cpu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .clock        (clock),
        .rst          (rst),
        .start        (start),
        .io_in        (io_in),
        .host_req     (host_req),
        .host_rdata   (host_rdata),
        .io_out       (io_out),
        .io_out_valid (io_out_valid),
        .busy         (busy)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial
    begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + 100));
        $display("TIMEOUT: the core or the host port did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // io writes, sampled mid-cycle.
    always @(negedge clock)
    begin
        if (!rst && io_out_valid)
            dut_io.push_back(io_out);
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected)
        begin
            $display("CHECK FAILED %s: got 0x%04h, expected 0x%04h", name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
        host_req.en    = 1'b1;
        host_req.we    = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        @(posedge clock);
        #1;
        host_req = '0;
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [15:0] data);
        host_req.en    = 1'b1;
        host_req.we    = 1'b0;
        host_req.addr  = addr;
        host_req.wdata = '0;
        @(posedge clock);
        #1;
        data     = host_rdata;              // one cycle after the request.
        host_req = '0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] make_word(input cpu_isa_pkg::opcode_e op,
                                              input logic [3:0] rd, input logic [7:0] operand);
        return {op, rd, operand};
    endfunction

    // alu op, li or nop.
    function automatic logic [15:0] plain_word();
        int k;
        k = $urandom_range(0, 8);
        if (k <= 5)
            return make_word(cpu_isa_pkg::opcode_e'(4'(k)), 4'($urandom), 8'($urandom));
        else if (k <= 7)
            return make_word(cpu_isa_pkg::OP_LI, 4'($urandom), 8'($urandom));
        else
            return make_word(cpu_isa_pkg::opcode_e'(4'($urandom_range(10, 14))),
                             4'($urandom), 8'($urandom));
    endfunction

    task automatic emit_word(input logic [15:0] word);
        image[prog_len] = word;
        prog_len        = prog_len + 1;
    endtask

    task automatic build_program();
        int         kind;
        int         ea;
        int         base;
        int         target;
        logic [3:0] rb;
        logic [3:0] imm4;
        prog_len = 0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            kind = $urandom_range(0, 5);
            rb   = 4'($urandom);
            if (kind == 2 || kind == 3)
            begin
                if ($urandom_range(0, 3) == 0)
                begin
                    imm4 = 4'($urandom);
                    base = 65535 - int'(imm4);  // lands on the io word.
                end
                else
                begin
                    ea   = $urandom_range(128, 254);
                    imm4 = 4'($urandom_range(0, (ea - 128 > 15) ? 15 : ea - 128));
                    base = ea - int'(imm4);     // negative li, wraps into the data area.
                end
                emit_word(make_word(cpu_isa_pkg::OP_LI, rb, 8'(base)));
                emit_word(make_word((kind == 2) ? cpu_isa_pkg::OP_LD : cpu_isa_pkg::OP_ST,
                                    4'($urandom), {rb, imm4}));
            end
            else if (kind == 4)
            begin
                // forward only, onto a slot start.
                target = $urandom_range(s + 1, NUM_SLOTS);
                emit_word(make_word(cpu_isa_pkg::OP_BNZ, 4'($urandom), 8'(2 * (target - s) - 1)));
                emit_word(plain_word());
            end
            else
            begin
                emit_word(plain_word());
                emit_word(plain_word());
            end
        end
        emit_word(make_word(cpu_isa_pkg::OP_LI, 4'hF, 8'hFF));
        for (int r = 0; r < 16; r++)
            emit_word(make_word(cpu_isa_pkg::OP_ST, 4'(r), 8'hF0));
        emit_word(make_word(cpu_isa_pkg::OP_HALT, 4'h0, 8'h00));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one test
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_test();
        logic [15:0] word;
        logic [15:0] io_value;
        int          cycles;
        build_program();
        for (int a = 128; a < 255; a++)
            image[a] = 16'($urandom);
        for (int a = 0; a < prog_len; a++)
            write_word(16'(a), image[a]);
        for (int a = 128; a < 255; a++)
            write_word(16'(a), image[a]);
        for (int a = 0; a < prog_len; a++)
        begin
            read_word(16'(a), word);
            check_value("host_rdata", word, image[a]);
        end

        io_value = 16'($urandom);
        for (int a = 0; a < MEM_WORDS; a++)
            model_mem[a] = image[a];
        run_model(io_value);

        dut_io.delete();
        io_in = io_value;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        check_value("busy", 16'(busy), 16'h1);
        cycles = 0;
        while (busy)
        begin
            @(posedge clock);
            #1;
            cycles = cycles + 1;
        end
        check_value("run_cycles", 16'(cycles), 16'(model_cycles));

        check_value("io_write_count", 16'(dut_io.size()), 16'(model_io.size()));
        for (int i = 0; i < model_io.size(); i++)
            check_value("io_out", dut_io[i], model_io[i]);
        for (int a = 128; a < 255; a++)
        begin
            read_word(16'(a), word);
            check_value("data_word", word, model_mem[a]);
        end
    endtask

    initial
    begin
        void'($urandom(32'hd125_5b32));
        rst      = 1'b1;
        start    = 1'b0;
        io_in    = '0;
        host_req = '0;
        for (int r = 0; r < 16; r++)
            model_regs[r] = '0;
        repeat (5) @(posedge clock);
        #1;
        rst = 1'b0;
        check_value("busy", 16'(busy), 16'h0);
        check_value("io_out_valid", 16'(io_out_valid), 16'h0);
        check_value("io_out", io_out, 16'h0);

        // registers carry over from one program to the next.
        for (int t = 0; t < NUM_TESTS; t++)
            run_test();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- design/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_isa_pkg::alu_op_e           op,
    input  logic [cpu_isa_pkg::DATA_W-1:0] a,
    input  logic [cpu_isa_pkg::DATA_W-1:0] b,
    output logic [cpu_isa_pkg::DATA_W-1:0] y
);

    logic less;

    assign less = ($signed(a) < $signed(b));   // signed compare.

    always_comb
    begin
        case (op)
            cpu_isa_pkg::ALU_ADD: y = a + b;
            cpu_isa_pkg::ALU_SUB: y = a - b;
            cpu_isa_pkg::ALU_AND: y = a & b;
            cpu_isa_pkg::ALU_OR:  y = a | b;
            cpu_isa_pkg::ALU_XOR: y = a ^ b;
            cpu_isa_pkg::ALU_SLT: y = {{(cpu_isa_pkg::DATA_W-1){1'b0}}, less};
            default:              y = '0;
        endcase
    end

endmodule

//--- design/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  cpu_isa_pkg::instr_t instr,
    output cpu_ctrl_pkg::ctrl_t ctrl,
    output logic                busy
);

    cpu_ctrl_pkg::state_e state;
    cpu_ctrl_pkg::state_e state_next;
    logic                 is_rtype;

    assign is_rtype = instr.op inside {cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB,
                                       cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_OR,
                                       cpu_isa_pkg::OP_XOR, cpu_isa_pkg::OP_SLT};

    assign busy = (state != cpu_ctrl_pkg::S_HALTED);

    always_ff @(posedge clock)
    begin
        if (rst)
            state <= cpu_ctrl_pkg::S_HALTED;
        else
            state <= state_next;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        state_next = state;
        case (state)
            cpu_ctrl_pkg::S_HALTED: if (start) state_next = cpu_ctrl_pkg::S_FETCH;
            cpu_ctrl_pkg::S_FETCH:  state_next = cpu_ctrl_pkg::S_DECODE;
            cpu_ctrl_pkg::S_DECODE:
            begin
                if (instr.op == cpu_isa_pkg::OP_HALT)
                    state_next = cpu_ctrl_pkg::S_HALTED;
                else if (is_rtype || instr.op inside {cpu_isa_pkg::OP_LI, cpu_isa_pkg::OP_LD,
                                                     cpu_isa_pkg::OP_ST, cpu_isa_pkg::OP_BNZ})
                    state_next = cpu_ctrl_pkg::S_EXEC;
                else
                    state_next = cpu_ctrl_pkg::S_FETCH;    // nop.
            end
            cpu_ctrl_pkg::S_EXEC:
            begin
                if (instr.op inside {cpu_isa_pkg::OP_LD, cpu_isa_pkg::OP_ST})
                    state_next = cpu_ctrl_pkg::S_MEM;
                else if (instr.op == cpu_isa_pkg::OP_BNZ)
                    state_next = cpu_ctrl_pkg::S_FETCH;
                else
                    state_next = cpu_ctrl_pkg::S_WB;
            end
            cpu_ctrl_pkg::S_MEM:
            begin
                if (instr.op == cpu_isa_pkg::OP_LD)
                    state_next = cpu_ctrl_pkg::S_WB;
                else
                    state_next = cpu_ctrl_pkg::S_FETCH;
            end
            default: state_next = cpu_ctrl_pkg::S_FETCH;   // writeback.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        ctrl = '0;
        case (state)
            cpu_ctrl_pkg::S_FETCH:
            begin
                ctrl.mem_en    = 1'b1;
                ctrl.addr_sel  = cpu_ctrl_pkg::ADDR_PC;
                ctrl.ir_write  = 1'b1;
                ctrl.alu_src_a = cpu_ctrl_pkg::SRC_A_PC;
                ctrl.alu_src_b = cpu_ctrl_pkg::SRC_B_ONE;
                ctrl.pc_write  = 1'b1;                     // pc + 1.
            end
            cpu_ctrl_pkg::S_DECODE:
            begin
                ctrl.alu_src_a = cpu_ctrl_pkg::SRC_A_PC;
                ctrl.alu_src_b = cpu_ctrl_pkg::SRC_B_IMM8; // branch target.
            end
            cpu_ctrl_pkg::S_EXEC:
            begin
                if (is_rtype)
                begin
                    ctrl.alu_src_a = cpu_ctrl_pkg::SRC_A_REG;
                    ctrl.alu_src_b = cpu_ctrl_pkg::SRC_B_REG;
                    ctrl.alu_op    = cpu_isa_pkg::alu_op_e'(instr.op[2:0]);
                end
                else if (instr.op inside {cpu_isa_pkg::OP_LD, cpu_isa_pkg::OP_ST})
                begin
                    ctrl.alu_src_a = cpu_ctrl_pkg::SRC_A_REG;
                    ctrl.alu_src_b = cpu_ctrl_pkg::SRC_B_IMM4;
                    ctrl.addr_sel  = cpu_ctrl_pkg::ADDR_ALU;
                    ctrl.mem_en    = (instr.op == cpu_isa_pkg::OP_LD);
                end
                else if (instr.op == cpu_isa_pkg::OP_BNZ)
                    ctrl.pc_write_cond = 1'b1;
            end
            cpu_ctrl_pkg::S_MEM:
            begin
                ctrl.alu_src_a = cpu_ctrl_pkg::SRC_A_REG;
                ctrl.alu_src_b = cpu_ctrl_pkg::SRC_B_IMM4;
                ctrl.addr_sel  = cpu_ctrl_pkg::ADDR_ALU;
                ctrl.mem_en    = (instr.op == cpu_isa_pkg::OP_ST);
                ctrl.mem_we    = (instr.op == cpu_isa_pkg::OP_ST);
            end
            cpu_ctrl_pkg::S_WB:
            begin
                ctrl.reg_write = 1'b1;
                if (instr.op == cpu_isa_pkg::OP_LD)
                    ctrl.wb_sel = cpu_ctrl_pkg::WB_MDR;
                else if (instr.op == cpu_isa_pkg::OP_LI)
                    ctrl.wb_sel = cpu_ctrl_pkg::WB_IMM8;
                else
                    ctrl.wb_sel = cpu_ctrl_pkg::WB_ALU;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        S_FETCH  = 3'd0,
        S_DECODE = 3'd1,
        S_EXEC   = 3'd2,
        S_MEM    = 3'd3,
        S_WB     = 3'd4,
        S_HALTED = 3'd5
    } state_e;

    typedef enum logic {ADDR_PC, ADDR_ALU} addr_sel_e;
    typedef enum logic {SRC_A_PC, SRC_A_REG} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_ONE, SRC_B_IMM4, SRC_B_IMM8} src_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_MDR, WB_IMM8} wb_sel_e;

    typedef struct packed {
        logic                 pc_write;
        logic                 pc_write_cond;   // taken only if reg rd is nonzero.
        logic                 ir_write;        // ir loads on the following cycle.
        addr_sel_e            addr_sel;
        src_a_e               alu_src_a;
        src_b_e               alu_src_b;
        cpu_isa_pkg::alu_op_e alu_op;
        logic                 reg_write;
        wb_sel_e              wb_sel;
        logic                 mem_en;
        logic                 mem_we;
    } ctrl_t;

    typedef struct packed {
        logic                             en;
        logic                             we;
        logic [cpu_isa_pkg::DATA_W-1:0]   addr;
        logic [cpu_isa_pkg::DATA_W-1:0]   wdata;
    } mem_req_t;

endpackage

//--- design/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               start,
    input  cpu_ctrl_pkg::ctrl_t                ctrl,
    input  logic [cpu_isa_pkg::DATA_W-1:0]     mem_rdata,
    output cpu_isa_pkg::instr_t                instr,
    output cpu_ctrl_pkg::mem_req_t             mem_req
);

    localparam int W = cpu_isa_pkg::DATA_W;

    logic [W-1:0]        pc;
    logic [W-1:0]        mdr;
    logic [W-1:0]        a_q;
    logic [W-1:0]        b_q;
    logic [W-1:0]        alu_out;
    cpu_isa_pkg::instr_t ir;
    logic                ir_pending;
    logic [W-1:0]        rd1;
    logic [W-1:0]        rd2;
    logic [W-1:0]        alu_a;
    logic [W-1:0]        alu_b;
    logic [W-1:0]        alu_y;
    logic [W-1:0]        wb_data;
    logic [W-1:0]        imm4_zx;
    logic [W-1:0]        imm8_sx;
    logic [3:0]          ra2;
    logic                pc_load;

    // fetched word is decoded straight off the memory bus.
    assign instr = ir_pending ? cpu_isa_pkg::instr_t'(mem_rdata) : ir;

    assign ra2 = (instr.op inside {cpu_isa_pkg::OP_ST, cpu_isa_pkg::OP_BNZ}) ? instr.rd
                                                                             : instr.rs2;
    assign imm4_zx = W'(instr.rs2);
    assign imm8_sx = {{(W-8){instr.rs1[3]}}, instr.rs1, instr.rs2};

    cpu_regfile regfile_i (
        .clock (clock),
        .rst   (rst),
        .ra1   (instr.rs1),
        .ra2   (ra2),
        .wa    (instr.rd),
        .we    (ctrl.reg_write),
        .wdata (wb_data),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign alu_a = (ctrl.alu_src_a == cpu_ctrl_pkg::SRC_A_PC) ? pc : a_q;

    always_comb
    begin
        case (ctrl.alu_src_b)
            cpu_ctrl_pkg::SRC_B_REG:  alu_b = b_q;
            cpu_ctrl_pkg::SRC_B_ONE:  alu_b = W'(1);
            cpu_ctrl_pkg::SRC_B_IMM4: alu_b = imm4_zx;
            default:                  alu_b = imm8_sx;
        endcase
    end

    cpu_alu alu_i (
        .op (ctrl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_comb
    begin
        case (ctrl.wb_sel)
            cpu_ctrl_pkg::WB_MDR:  wb_data = mdr;
            cpu_ctrl_pkg::WB_IMM8: wb_data = imm8_sx;
            default:               wb_data = alu_out;
        endcase
    end

    // b holds reg rd during a branch.
    assign pc_load = ctrl.pc_write || (ctrl.pc_write_cond && (b_q != '0));

    always_ff @(posedge clock)
    begin
        if (rst || start)
            pc <= '0;
        else if (pc_load)
            pc <= ctrl.pc_write_cond ? alu_out : alu_y;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            ir_pending <= 1'b0;
            ir         <= '0;
        end
        else
        begin
            ir_pending <= ctrl.ir_write;
            if (ir_pending)
                ir <= cpu_isa_pkg::instr_t'(mem_rdata);
        end
    end

    always_ff @(posedge clock)
    begin
        a_q     <= rd1;
        b_q     <= rd2;
        mdr     <= mem_rdata;
        alu_out <= alu_y;
    end

    always_comb
    begin
        mem_req.en    = ctrl.mem_en;
        mem_req.we    = ctrl.mem_we;
        mem_req.addr  = (ctrl.addr_sel == cpu_ctrl_pkg::ADDR_PC) ? pc : alu_y;
        mem_req.wdata = b_q;
    end

endmodule

//--- design/cpu_isa_pkg.sv
package cpu_isa_pkg;

    parameter int DATA_W = 16;

    // the single memory-mapped I/O word.
    parameter logic [DATA_W-1:0] IO_ADDR = 16'hFFFF;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLT  = 4'h5,
        OP_LI   = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_BNZ  = 4'h9,
        OP_HALT = 4'hF       // 4'hA to 4'hE decode as nop.
    } opcode_e;

    typedef struct packed {
        opcode_e    op;
        logic [3:0] rd;
        logic [3:0] rs1;     // high half of imm8.
        logic [3:0] rs2;     // also imm4, low half of imm8.
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

endpackage

//--- design/cpu_memory.sv
`timescale 1ns/1ps

module cpu_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clock,
    input  logic                           rst,
    input  cpu_ctrl_pkg::mem_req_t         core_req,
    input  cpu_ctrl_pkg::mem_req_t         host_req,
    input  logic [cpu_isa_pkg::DATA_W-1:0] io_in,
    output logic [cpu_isa_pkg::DATA_W-1:0] rdata,
    output logic [cpu_isa_pkg::DATA_W-1:0] host_rdata,
    output logic [cpu_isa_pkg::DATA_W-1:0] io_out,
    output logic                           io_out_valid
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [cpu_isa_pkg::DATA_W-1:0] ram [MEM_WORDS];
    cpu_ctrl_pkg::mem_req_t         req;
    logic [AW-1:0]                  idx;
    logic                           is_io;
    logic                           io_write;
    logic [cpu_isa_pkg::DATA_W-1:0] rd_q;

    assign req      = core_req.en ? core_req : host_req;   // core first.
    assign idx      = AW'(req.addr % MEM_WORDS);            // wraps.
    assign is_io    = (req.addr == cpu_isa_pkg::IO_ADDR);
    assign io_write = core_req.en && core_req.we && is_io;

    always_ff @(posedge clock)
    begin
        if (req.en && req.we && !is_io)
            ram[idx] <= req.wdata;
        if (req.en && !req.we)
            rd_q <= is_io ? io_in : ram[idx];
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            io_out       <= '0;
            io_out_valid <= 1'b0;
        end
        else
        begin
            io_out_valid <= io_write;
            if (io_write)
                io_out <= core_req.wdata;
        end
    end

    // one read port, shared by core and host.
    assign rdata      = rd_q;
    assign host_rdata = rd_q;

endmodule

//--- design/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [3:0]                     ra1,
    input  logic [3:0]                     ra2,
    input  logic [3:0]                     wa,
    input  logic                           we,
    input  logic [cpu_isa_pkg::DATA_W-1:0] wdata,
    output logic [cpu_isa_pkg::DATA_W-1:0] rd1,
    output logic [cpu_isa_pkg::DATA_W-1:0] rd2
);

    logic [cpu_isa_pkg::DATA_W-1:0] regs [16];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[wa] <= wdata;
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clock,
    input  logic                           rst,
    input  logic                           start,
    input  logic [cpu_isa_pkg::DATA_W-1:0] io_in,
    input  cpu_ctrl_pkg::mem_req_t         host_req,
    output logic [cpu_isa_pkg::DATA_W-1:0] host_rdata,
    output logic [cpu_isa_pkg::DATA_W-1:0] io_out,
    output logic                           io_out_valid,
    output logic                           busy
);

    cpu_ctrl_pkg::ctrl_t            ctrl;
    cpu_isa_pkg::instr_t            instr;
    cpu_ctrl_pkg::mem_req_t         core_req;
    logic [cpu_isa_pkg::DATA_W-1:0] mem_rdata;

    cpu_control control_i (
        .clock (clock),
        .rst   (rst),
        .start (start),
        .instr (instr),
        .ctrl  (ctrl),
        .busy  (busy)
    );

    cpu_datapath datapath_i (
        .clock     (clock),
        .rst       (rst),
        .start     (start),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .instr     (instr),
        .mem_req   (core_req)
    );

    cpu_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) memory_i (
        .clock        (clock),
        .rst          (rst),
        .core_req     (core_req),
        .host_req     (host_req),
        .io_in        (io_in),
        .rdata        (mem_rdata),
        .host_rdata   (host_rdata),
        .io_out       (io_out),
        .io_out_valid (io_out_valid)
    );

endmodule

//--- files.f
+incdir+bench
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_alu.sv
design/cpu_regfile.sv
design/cpu_control.sv
design/cpu_datapath.sv
design/cpu_memory.sv
design/cpu_top.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the cpu testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
